/* logic/uart_pkg.sv */
`default_nettype none

package uart_pkg;

  //////////////////////////////////////////////////
  // Line timing

  localparam int BIT_CYCLES        = 434;  // 50 MHz clock at 115200 baud
  localparam int HALF_BIT          = BIT_CYCLES / 2;
  localparam int GAP_BITS          = 2;
  localparam int RESP_TIMEOUT_BITS = 40;
  localparam int FRAME_BITS        = 11;   // Start, 8 data, parity, stop

  localparam int GAP_CYCLES     = GAP_BITS * BIT_CYCLES;
  localparam int TIMEOUT_CYCLES = RESP_TIMEOUT_BITS * BIT_CYCLES;

  // Counter widths follow from the constants above
  localparam int BIT_CNT_W = $clog2(BIT_CYCLES);
  localparam int IDX_W     = $clog2(FRAME_BITS);
  localparam int GAP_CNT_W = $clog2(GAP_CYCLES);
  localparam int TO_CNT_W  = $clog2(TIMEOUT_CYCLES);

  //////////////////////////////////////////////////
  // Received frame

  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;  // Parity bit disagrees with even parity of data
    logic       stop_err;    // Stop bit sampled low
  } rx_status_t;

endpackage

`default_nettype wire

/* logic/cmd_pkg.sv */
`default_nettype none

package cmd_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_t;

  // Op and addr together form the command byte sent first on the line
  typedef struct packed {
    op_t        op;
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_t;

  typedef enum logic [2:0] {
    IDLE,
    SEND_CMD,
    GAP,
    SEND_DATA,
    WAIT_RESP,
    DONE
  } seq_state_t;

  // Result of a read, data is zero when the device never answered
  typedef struct packed {
    logic [7:0] data;
    logic       err;
  } rd_resp_t;

endpackage

`default_nettype wire

/* logic/uart_tx_frame.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_frame (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       tx_start,
  input  wire logic [7:0] tx_byte,
  output logic            tx,
  output logic            tx_busy
);

  logic [uart_pkg::BIT_CNT_W-1:0] bit_cnt;
  logic [uart_pkg::IDX_W-1:0]     bit_idx;
  logic [9:0]                     shift_reg;  // Data, parity and stop still to go
  logic                           load;
  logic                           bit_end;
  logic                           parity;

  assign load    = tx_start && !tx_busy;
  assign bit_end = bit_cnt == uart_pkg::BIT_CYCLES - 1;
  assign parity  = ^tx_byte;  // Even parity over the data byte

  //////////////////////////////////////////////////
  // Bit timing and line driver

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx      <= 1'b1;
      tx_busy <= 1'b0;
      bit_cnt <= '0;
      bit_idx <= '0;
    end
    else if (load)
    begin
      tx      <= 1'b0;  // Start bit goes out right away
      tx_busy <= 1'b1;
      bit_cnt <= '0;
      bit_idx <= '0;
    end
    else if (tx_busy)
    begin
      if (bit_end)
      begin
        bit_cnt <= '0;
        if (bit_idx == uart_pkg::FRAME_BITS - 1)
        begin
          // End of the stop bit, line stays high
          tx      <= 1'b1;
          tx_busy <= 1'b0;
        end
        else
        begin
          tx      <= shift_reg[0];
          bit_idx <= bit_idx + 1'b1;
        end
      end
      else
      begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Shift register, LSB leaves first

  always_ff @(posedge clk)
  begin
    if (load)
      shift_reg <= {1'b1, parity, tx_byte};
    else if (tx_busy && bit_end)
      shift_reg <= {1'b1, shift_reg[9:1]};  // Fill with idle level
  end

endmodule

`default_nettype wire

/* logic/uart_rx_frame.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_frame (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           rx_arm,
  input  wire logic           rx,
  output logic                rx_done,
  output logic                rx_timeout,
  output uart_pkg::rx_status_t rx_status
);

  logic                           rx_meta;
  logic                           rx_sync;
  logic                           rx_prev;
  logic                           waiting;    // Armed, looking for a start bit
  logic                           receiving;
  logic [uart_pkg::TO_CNT_W-1:0]  to_cnt;
  logic [uart_pkg::BIT_CNT_W-1:0] bit_cnt;
  logic [uart_pkg::IDX_W-1:0]     bit_idx;
  logic [7:0]                     shift_reg;
  logic                           parity_bit;
  logic                           fall;
  logic                           mid_bit;
  logic                           bit_end;

  assign fall    = rx_prev && !rx_sync;
  assign mid_bit = bit_cnt == uart_pkg::HALF_BIT - 1;
  assign bit_end = bit_cnt == uart_pkg::BIT_CYCLES - 1;

  // Two-flop synchronizer, then one more stage for the edge detector
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  //////////////////////////////////////////////////
  // Control

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      waiting    <= 1'b0;
      receiving  <= 1'b0;
      to_cnt     <= '0;
      bit_cnt    <= '0;
      bit_idx    <= '0;
      rx_done    <= 1'b0;
      rx_timeout <= 1'b0;
    end
    else
    begin
      rx_done    <= 1'b0;
      rx_timeout <= 1'b0;
      if (rx_arm)
      begin
        waiting <= 1'b1;
        to_cnt  <= '0;
      end
      else if (waiting)
      begin
        if (fall)
        begin
          waiting   <= 1'b0;
          receiving <= 1'b1;
          bit_cnt   <= '0;  // Bit times now run from the falling edge
          bit_idx   <= '0;
        end
        else if (to_cnt == uart_pkg::TIMEOUT_CYCLES - 1)
        begin
          waiting    <= 1'b0;
          rx_timeout <= 1'b1;
        end
        else
        begin
          to_cnt <= to_cnt + 1'b1;
        end
      end
      else if (receiving)
      begin
        bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
        if (bit_end)
          bit_idx <= bit_idx + 1'b1;
        if (mid_bit && bit_idx == uart_pkg::FRAME_BITS - 1)
        begin
          receiving <= 1'b0;  // Done halfway into the stop bit
          rx_done   <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Mid-bit sampling

  always_ff @(posedge clk)
  begin
    if (receiving && mid_bit)
    begin
      if (bit_idx >= 4'd1 && bit_idx <= 4'd8)
        shift_reg <= {rx_sync, shift_reg[7:1]};  // LSB arrives first
      else if (bit_idx == 4'd9)
        parity_bit <= rx_sync;
      else if (bit_idx == uart_pkg::FRAME_BITS - 1)
      begin
        rx_status.data       <= shift_reg;
        rx_status.parity_err <= ^{shift_reg, parity_bit};
        rx_status.stop_err   <= !rx_sync;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/cmd_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire cmd_pkg::cmd_t        cmd,
  input  wire logic                 cmd_vld,
  output logic                      cmd_rdy,
  output logic                      tx_start,
  output logic [7:0]                tx_byte,
  input  wire logic                 tx_busy,
  output logic                      rx_arm,
  input  wire logic                 rx_done,
  input  wire logic                 rx_timeout,
  input  wire uart_pkg::rx_status_t rx_status,
  output logic                      read_rdy,
  output cmd_pkg::rd_resp_t         read_resp
);

  cmd_pkg::seq_state_t            state;
  cmd_pkg::cmd_t                  cmd_q;
  logic [uart_pkg::GAP_CNT_W-1:0] gap_cnt;
  logic                           frame_done;

  assign cmd_rdy  = state == cmd_pkg::IDLE;
  assign read_rdy = state == cmd_pkg::DONE;  // DONE lasts exactly one cycle

  // The tx_start cycle comes before tx_busy rises, so it must not count as done
  assign frame_done = !tx_start && !tx_busy;

  assign tx_byte = (state == cmd_pkg::SEND_DATA) ? cmd_q.data : {cmd_q.op, cmd_q.addr};

  // Command held for the whole transaction
  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
      cmd_q <= cmd;
  end

  //////////////////////////////////////////////////
  // Sequencer FSM

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= cmd_pkg::IDLE;
      tx_start  <= 1'b0;
      rx_arm    <= 1'b0;
      gap_cnt   <= '0;
      read_resp <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      rx_arm   <= 1'b0;

      case (state)
        cmd_pkg::IDLE:
        begin
          if (cmd_vld)
          begin
            state    <= cmd_pkg::SEND_CMD;
            tx_start <= 1'b1;  // Command byte first for both kinds
          end
        end

        cmd_pkg::SEND_CMD:
        begin
          if (frame_done)
          begin
            if (cmd_q.op == cmd_pkg::OP_WRITE)
            begin
              state   <= cmd_pkg::GAP;
              gap_cnt <= '0;
            end
            else
            begin
              state  <= cmd_pkg::WAIT_RESP;
              rx_arm <= 1'b1;
            end
          end
        end

        cmd_pkg::GAP:
        begin
          // One cycle to get here and two to start the next frame make up the rest
          if (gap_cnt == uart_pkg::GAP_CYCLES - 3)
          begin
            state    <= cmd_pkg::SEND_DATA;
            tx_start <= 1'b1;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end

        cmd_pkg::SEND_DATA:
        begin
          if (frame_done)
            state <= cmd_pkg::IDLE;
        end

        cmd_pkg::WAIT_RESP:
        begin
          if (rx_timeout)
          begin
            read_resp.data <= 8'h00;  // Nothing arrived
            read_resp.err  <= 1'b1;
            state          <= cmd_pkg::DONE;
          end
          else if (rx_done)
          begin
            read_resp.data <= rx_status.data;  // Kept even when the frame is bad
            read_resp.err  <= rx_status.parity_err | rx_status.stop_err;
            state          <= cmd_pkg::DONE;
          end
        end

        cmd_pkg::DONE:
        begin
          state <= cmd_pkg::IDLE;
        end

        default:
        begin
          state <= cmd_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/uart_cmd_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_bridge (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire cmd_pkg::cmd_t cmd,
  input  wire logic          cmd_vld,
  output logic               cmd_rdy,
  input  wire logic          rx,
  output logic               tx,
  output logic               read_rdy,
  output logic [7:0]         read_data,
  output logic               read_err
);

  logic                 tx_start;
  logic [7:0]           tx_byte;
  logic                 tx_busy;
  logic                 rx_arm;
  logic                 rx_done;
  logic                 rx_timeout;
  uart_pkg::rx_status_t rx_status;
  cmd_pkg::rd_resp_t    read_resp;

  assign read_data = read_resp.data;
  assign read_err  = read_resp.err;

  cmd_sequencer u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .tx_start   (tx_start),
    .tx_byte    (tx_byte),
    .tx_busy    (tx_busy),
    .rx_arm     (rx_arm),
    .rx_done    (rx_done),
    .rx_timeout (rx_timeout),
    .rx_status  (rx_status),
    .read_rdy   (read_rdy),
    .read_resp  (read_resp)
  );

  uart_tx_frame u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  // Only armed during reads, so rx traffic during a write is never seen
  uart_rx_frame u_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_arm     (rx_arm),
    .rx         (rx),
    .rx_done    (rx_done),
    .rx_timeout (rx_timeout),
    .rx_status  (rx_status)
  );

endmodule

`default_nettype wire

/* bench/bridge_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module bridge_checker (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic cmd_vld,
  input wire logic cmd_rdy,
  input wire logic tx,
  input wire logic read_rdy
);

  int unsigned assert_fails = 0;

  // An idle bridge holds the line at its idle level
  tx_idle: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
    else
    begin
      assert_fails++;
      $error("tx was low while cmd_rdy was high");
    end

  accept_busy: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_vld && cmd_rdy |=> !cmd_rdy)
    else
    begin
      assert_fails++;
      $error("cmd_rdy stayed high in the cycle after a command was taken");
    end

  rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else
    begin
      assert_fails++;
      $error("read_rdy was high on two cycles in a row");
    end

endmodule

bind uart_cmd_bridge bridge_checker chk0 (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_rdy (read_rdy)
);

`default_nettype wire

/* bench/uart_device_model.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_device_model (
  input  wire logic  clk,
  input  wire logic  tx,
  input  wire logic  corrupt_parity,
  input  wire logic  stay_silent,
  output logic       rx,
  output logic       frame_vld,
  output logic [7:0] frame_byte,
  output logic       frame_par,
  output logic [31:0] frame_start
);

  logic [7:0]  mem [0:127];
  logic [31:0] cyc;
  logic        data_next;  // Next frame carries write data
  logic [6:0]  wr_addr;
  logic [7:0]  resp_byte;
  event        resp_go;

  initial
  begin
    rx          = 1'b1;
    frame_vld   = 1'b0;
    frame_byte  = 8'h00;
    frame_par   = 1'b0;
    frame_start = '0;
    cyc         = '0;
    data_next   = 1'b0;
    wr_addr     = '0;
    resp_byte   = 8'h00;
    for (int i = 0; i < 128; i++)
      mem[i] = 8'h00;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  task automatic send_bit(input logic b);
    @(posedge clk);
    #2;
    rx = b;
    repeat (uart_pkg::BIT_CYCLES - 1) @(posedge clk);
  endtask

  //////////////////////////////////////////////////
  // Frame decoder on tx, sampled mid-bit

  always
  begin
    @(negedge clk);
    if (tx === 1'b0)
    begin
      frame_start = cyc;
      repeat (uart_pkg::HALF_BIT) @(negedge clk);
      for (int i = 0; i < 8; i++)
      begin
        repeat (uart_pkg::BIT_CYCLES) @(negedge clk);
        frame_byte[i] = tx;
      end
      repeat (uart_pkg::BIT_CYCLES) @(negedge clk);
      frame_par = tx;
      repeat (uart_pkg::BIT_CYCLES) @(negedge clk);  // Middle of the stop bit
      if (data_next)
      begin
        mem[wr_addr] = frame_byte;
        data_next    = 1'b0;
      end
      else if (frame_byte[7])
      begin
        wr_addr   = frame_byte[6:0];
        data_next = 1'b1;
      end
      else if (!stay_silent)
      begin
        resp_byte = mem[frame_byte[6:0]];
        -> resp_go;
      end
      frame_vld = 1'b1;
      @(negedge clk);
      frame_vld = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Read response on rx

  always
  begin
    @(resp_go);
    // Rest of the stop bit, then three idle bit times
    repeat (uart_pkg::HALF_BIT + 3 * uart_pkg::BIT_CYCLES) @(posedge clk);
    send_bit(1'b0);
    for (int i = 0; i < 8; i++)
      send_bit(resp_byte[i]);
    send_bit(^resp_byte ^ corrupt_parity);
    send_bit(1'b1);
  end

endmodule

`default_nettype wire

/* bench/cmd_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_scoreboard (
  input wire logic        clk,
  input wire logic        cmd_vld,
  input wire logic        cmd_rdy,
  input wire logic        tx,
  input wire logic        read_rdy,
  input wire logic [7:0]  read_data,
  input wire logic        read_err,
  input wire logic        frame_vld,
  input wire logic [7:0]  frame_byte,
  input wire logic        frame_par,
  input wire logic [31:0] frame_start
);

  localparam int FRAME_CYCLES = uart_pkg::FRAME_BITS * uart_pkg::BIT_CYCLES;

  typedef struct packed {
    logic [7:0] value;
    logic       par;
    logic       gap_check;  // Spacing is measured on the data frame of a write
  } frame_exp_t;

  typedef struct packed {
    logic [7:0]  data;
    logic        err;
    logic [31:0] min_lat;
  } read_exp_t;

  frame_exp_t  frame_q [$];
  read_exp_t   read_q [$];
  frame_exp_t  exp_f;
  read_exp_t   exp_r;
  string       test_name = "none";
  int unsigned test_errs = 0;
  int unsigned tests_passed = 0;
  int unsigned tests_failed = 0;
  logic [31:0] cyc = '0;
  logic [31:0] accept_cyc = '0;
  logic [31:0] last_start = '0;

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act)
    begin
      $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic report(input string msg);
    $display("ERROR %s: %s", test_name, msg);
    test_errs++;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (frame_q.size() != 0)
      report($sformatf("%0d expected frames never appeared on tx", frame_q.size()));
    if (read_q.size() != 0)
      report($sformatf("%0d reads never returned", read_q.size()));
    frame_q.delete();
    read_q.delete();
    if (test_errs == 0)
    begin
      tests_passed++;
      $display("TEST %s: passed", test_name);
    end
    else
    begin
      tests_failed++;
      $display("TEST %s: failed with %0d errors", test_name, test_errs);
    end
  endtask

  task automatic expect_frame(input logic [7:0] value, input logic par, input logic gap_check);
    frame_q.push_back({value, par, gap_check});
  endtask

  task automatic expect_read(input logic [7:0] data, input logic err, input logic [31:0] min_lat);
    read_q.push_back({data, err, min_lat});
  endtask

  task automatic check_idle_outputs();
    compare_value("tx", 32'd1, tx);
    compare_value("cmd_rdy", 32'd1, cmd_rdy);
    compare_value("read_rdy", 32'd0, read_rdy);
    compare_value("read_data", 32'd0, read_data);
    compare_value("read_err", 32'd0, read_err);
  endtask

  //////////////////////////////////////////////////
  // Frames decoded by the device model

  always @(posedge clk)
  begin
    if (frame_vld)
    begin
      if (frame_q.size() == 0)
        report($sformatf("unexpected frame %02h on tx", frame_byte));
      else
      begin
        exp_f = frame_q.pop_front();
        compare_value("frame byte", exp_f.value, frame_byte);
        compare_value("parity bit", exp_f.par, frame_par);
        if (exp_f.gap_check)
          compare_value("gap cycles", uart_pkg::GAP_BITS * uart_pkg::BIT_CYCLES,
                        frame_start - last_start - FRAME_CYCLES);
      end
      last_start = frame_start;
    end
  end

  // DUT ports are sampled at the falling edge between updates
  always @(negedge clk)
  begin
    cyc = cyc + 1;
    if (cmd_vld && cmd_rdy)
      accept_cyc = cyc;
    if (read_rdy)
    begin
      if (read_q.size() == 0)
        report("read_rdy pulsed with no read outstanding");
      else
      begin
        exp_r = read_q.pop_front();
        compare_value("read_data", exp_r.data, read_data);
        compare_value("read_err", exp_r.err, read_err);
        if (cyc - accept_cyc < exp_r.min_lat)
          report($sformatf("read ended %0d cycles after acceptance, before the timeout",
                           cyc - accept_cyc));
      end
    end
  end

endmodule

`default_nettype wire

/* bench/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  localparam int FRAME_CYCLES = uart_pkg::FRAME_BITS * uart_pkg::BIT_CYCLES;
  localparam int N_CMDS       = 30;
  localparam int N_SILENT     = 2;
  localparam int RUN_LIMIT    = N_CMDS * 3 * FRAME_CYCLES
                              + N_SILENT * uart_pkg::TIMEOUT_CYCLES + 20000;

  typedef struct packed {
    logic [7:0] cmd_byte;
    logic       cmd_par;
    logic [7:0] data_byte;
    logic       data_par;
  } frames_t;

  logic          clk;
  logic          rst_n;
  cmd_pkg::cmd_t cmd;
  logic          cmd_vld;
  logic          cmd_rdy;
  logic          rx;
  logic          tx;
  logic          read_rdy;
  logic [7:0]    read_data;
  logic          read_err;
  logic          corrupt_parity;
  logic          stay_silent;
  logic          frame_vld;
  logic [7:0]    frame_byte;
  logic          frame_par;
  logic [31:0]   frame_start;
  logic [7:0]    mirror [0:127];  // Expected contents of the remote registers
  logic          touched [0:127];
  logic [6:0]    written [$];
  int unsigned   cycles = 0;

  uart_cmd_bridge dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_device_model model0 (
    .clk            (clk),
    .tx             (tx),
    .corrupt_parity (corrupt_parity),
    .stay_silent    (stay_silent),
    .rx             (rx),
    .frame_vld      (frame_vld),
    .frame_byte     (frame_byte),
    .frame_par      (frame_par),
    .frame_start    (frame_start)
  );

  cmd_scoreboard sb0 (
    .clk         (clk),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .tx          (tx),
    .read_rdy    (read_rdy),
    .read_data   (read_data),
    .read_err    (read_err),
    .frame_vld   (frame_vld),
    .frame_byte  (frame_byte),
    .frame_par   (frame_par),
    .frame_start (frame_start)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles == RUN_LIMIT)
    begin
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // The command byte is bits 15:8 and each parity bit makes the count of ones even
  function automatic frames_t expected_frames(input cmd_pkg::cmd_t c);
    frames_t f;
    f.cmd_byte  = c[15:8];
    f.data_byte = c[7:0];
    f.cmd_par   = 1'b0;
    f.data_par  = 1'b0;
    for (int i = 0; i < 8; i++)
    begin
      f.cmd_par  = f.cmd_par ^ f.cmd_byte[i];
      f.data_par = f.data_par ^ f.data_byte[i];
    end
    return f;
  endfunction

  //////////////////////////////////////////////////
  // Host side of the command port

  task automatic issue(input cmd_pkg::cmd_t c, input bit hold_vld);
    frames_t f;
    f = expected_frames(c);
    sb0.expect_frame(f.cmd_byte, f.cmd_par, 1'b0);
    if (c.op == cmd_pkg::OP_WRITE)
    begin
      sb0.expect_frame(f.data_byte, f.data_par, 1'b1);
      mirror[c.addr]  = c.data;
      touched[c.addr] = 1'b1;
      written.push_back(c.addr);
    end
    // A held cmd_vld means the previous command was taken on the last edge
    if (!cmd_vld)
    begin
      @(posedge clk);
      #2;
    end
    cmd     = c;
    cmd_vld = 1'b1;
    do
      @(negedge clk);
    while (!cmd_rdy);
    @(posedge clk);  // Taken on this edge
    #2;
    if (!hold_vld)
      cmd_vld = 1'b0;
  endtask

  task automatic issue_write(input logic [6:0] a, input logic [7:0] d, input bit hold_vld);
    cmd_pkg::cmd_t c;
    c.op   = cmd_pkg::OP_WRITE;
    c.addr = a;
    c.data = d;
    issue(c, hold_vld);
  endtask

  task automatic issue_read(input logic [6:0] a, input bit hold_vld);
    cmd_pkg::cmd_t c;
    c.op   = cmd_pkg::OP_READ;
    c.addr = a;
    c.data = 8'($urandom);
    // A silent device leaves only the timeout, which returns zero
    if (stay_silent)
      sb0.expect_read(8'h00, 1'b1,
                      FRAME_CYCLES + uart_pkg::RESP_TIMEOUT_BITS * uart_pkg::BIT_CYCLES);
    else
      sb0.expect_read(mirror[a], corrupt_parity, 0);
    issue(c, hold_vld);
  endtask

  task automatic wait_idle();
    do
      @(negedge clk);
    while (!cmd_rdy);
  endtask

  initial
  begin
    logic [6:0] a;
    void'($urandom(35));
    rst_n          = 1'b0;
    cmd            = '0;
    cmd_vld        = 1'b0;
    corrupt_parity = 1'b0;
    stay_silent    = 1'b0;
    for (int i = 0; i < 128; i++)
    begin
      mirror[i]  = 8'h00;
      touched[i] = 1'b0;
    end
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    sb0.begin_test("reset_state");
    @(negedge clk);
    sb0.check_idle_outputs();
    sb0.end_test();

    sb0.begin_test("write_framing");
    repeat (10)
    begin
      issue_write(7'($urandom), 8'($urandom), 1'b0);
      wait_idle();
    end
    sb0.end_test();

    sb0.begin_test("read_back");
    repeat (6)
    begin
      issue_read(written[$urandom % written.size()], 1'b0);
      wait_idle();
    end
    repeat (2)
    begin
      do
        a = 7'($urandom);
      while (touched[a]);
      issue_read(a, 1'b0);
      wait_idle();
    end
    sb0.end_test();

    sb0.begin_test("corrupt_parity");
    corrupt_parity = 1'b1;
    repeat (2)
    begin
      issue_read(written[$urandom % written.size()], 1'b0);
      wait_idle();
    end
    corrupt_parity = 1'b0;
    sb0.end_test();

    sb0.begin_test("silent_device");
    stay_silent = 1'b1;
    repeat (N_SILENT)
    begin
      issue_read(written[$urandom % written.size()], 1'b0);
      wait_idle();
    end
    stay_silent = 1'b0;
    sb0.end_test();

    // cmd_vld stays high from the first command to the last
    sb0.begin_test("back_pressure");
    a = 7'($urandom);
    issue_write(a, 8'($urandom), 1'b1);
    issue_read(a, 1'b1);
    issue_write(a + 7'd1, 8'($urandom), 1'b1);
    issue_read(a + 7'd1, 1'b0);
    wait_idle();
    sb0.end_test();

    $display("Tests passed: %0d, tests failed: %0d, assertion failures: %0d",
             sb0.tests_passed, sb0.tests_failed, dut0.chk0.assert_fails);
    if (sb0.tests_failed == 0 && dut0.chk0.assert_fails == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
logic/uart_pkg.sv
logic/cmd_pkg.sv
logic/uart_tx_frame.sv
logic/uart_rx_frame.sv
logic/cmd_sequencer.sv
logic/uart_cmd_bridge.sv
bench/bridge_checker.sv
bench/uart_device_model.sv
bench/cmd_scoreboard.sv
bench/tb_top.sv
